// ==== include/descBuffer_config.svh ====
// Descriptor buffer configuration
// Depth, word widths and SRAM bank geometry
`ifndef DESCBUFFER_CONFIG_SVH
`define DESCBUFFER_CONFIG_SVH

// ==========================================================
// Buffer geometry
// ==========================================================
`define BUF_DEPTH      2048  // Entries in the buffer
`define BUF_ADDR_W     11    // Full RAM address width
`define BANK_DEPTH     1024  // Entries per SRAM macro
`define BANK_ADDR_W    10    // Macro address width

// ==========================================================
// Word layout
// ==========================================================
`define PAYLOAD_W      144   // Descriptor payload bits
`define PARITY_GROUPS  4     // Quarter parity, 36 bits each
`define WORD_W         149   // Payload + last + parity
`define LO_HALF_W      74    // Low macro of a bank
`define HI_HALF_W      75    // High macro of a bank

`endif

// ==== logic/memGeomPkg.sv ====
// RAM geometry types
// Address and word types shared by the SRAM wrapper and its users
`include "descBuffer_config.svh"

package memGeomPkg;

    // ==========================================================
    // Addresses
    // ==========================================================
    typedef logic [`BUF_ADDR_W-1:0]  ramAddrT;   // Full address, bit 10 picks bank
    typedef logic [`BANK_ADDR_W-1:0] bankAddrT;  // Address inside one macro

    // ==========================================================
    // Data
    // ==========================================================
    typedef logic [`WORD_W-1:0]      ramWordT;   // One stored descriptor word

endpackage

// ==== logic/descBufPkg.sv ====
// Descriptor buffer types
// Payload, parity, occupancy and control state, plus the parity function
`include "descBuffer_config.svh"

package descBufPkg;

    localparam int groupW = `PAYLOAD_W / `PARITY_GROUPS;  // 36 bits per parity group

    typedef logic [`PAYLOAD_W-1:0]     payloadT;  // Descriptor payload
    typedef logic [`PARITY_GROUPS-1:0] parityT;   // One bit per quarter
    typedef logic [`BUF_ADDR_W:0]      countT;    // 0 to 2048 inclusive

    typedef enum logic {
        stScrub,  // Zero-fill after reset
        stRun     // Normal push/pop
    } ctrlStateT;

    // Even parity per quarter of the payload
    function automatic parityT calcParity(input payloadT data);
        parityT par;
        par = '0;
        for (int g = 0; g < `PARITY_GROUPS; g++) begin
            par[g] = ^data[g*groupW +: groupW];  // XOR of one 36-bit group
        end
        return par;
    endfunction

endpackage

// ==== logic/tpSramMacro.sv ====
// Behavioral two-port SRAM macro, 1024 deep
// Read data registered on read enable, no output pipeline
`timescale 1ns/10ps
`include "descBuffer_config.svh"

module tpSramMacro #(
    parameter int width = 74  // Data bits per word
) (
    input  logic                 ClkB,
    input  logic                 wrEn,
    input  memGeomPkg::bankAddrT wrAddr,
    input  logic [width-1:0]     wrData,
    input  logic                 rdEn,
    input  memGeomPkg::bankAddrT rdAddr,
    output logic [width-1:0]     rdData
);

    logic [width-1:0] memArray [`BANK_DEPTH];  // Storage, no reset

    always_ff @(posedge ClkB) begin
        if (wrEn) begin
            memArray[wrAddr] <= wrData;  // Write port
        end
    end

    always_ff @(posedge ClkB) begin
        if (rdEn) begin
            rdData <= memArray[rdAddr];  // Q valid next cycle, holds otherwise
        end
    end

    // Enabled ports must carry a known address
    aWrAddrKnown: assert property (@(posedge ClkB) wrEn |-> !$isunknown(wrAddr));
    aRdAddrKnown: assert property (@(posedge ClkB) rdEn |-> !$isunknown(rdAddr));

endmodule

// ==== logic/bankedTpRam.sv ====
// Banked 2048x149 two-port RAM
// Two banks of 74+75-bit macros, bank picked by address bit 10
`timescale 1ns/10ps
`include "descBuffer_config.svh"

module bankedTpRam (
    input  logic                ClkB,
    input  logic                wrEn,
    input  memGeomPkg::ramAddrT wrAddr,
    input  memGeomPkg::ramWordT wrWord,
    input  logic                rdEn,
    input  memGeomPkg::ramAddrT rdAddr,
    output memGeomPkg::ramWordT rdWord
);

    import memGeomPkg::*;

    localparam int bankBit  = `BUF_ADDR_W - 1;          // Top address bit
    localparam int numBanks = `BUF_DEPTH / `BANK_DEPTH;  // Two banks

    ramWordT [numBanks-1:0] bankQ;  // Raw output of each bank
    bankAddrT               wrBankAddr;
    bankAddrT               rdBankAddr;
    logic                   rdBankQ;  // Read bank, one cycle late

    // ==========================================================
    // Address split
    // ==========================================================
    assign wrBankAddr = wrAddr[`BANK_ADDR_W-1:0];  // Same low bits to all macros
    assign rdBankAddr = rdAddr[`BANK_ADDR_W-1:0];

    // ==========================================================
    // Macro banks
    // ==========================================================
    for (genvar b = 0; b < numBanks; b++) begin : gBank
        logic wrSel;  // Write hits this bank
        logic rdSel;  // Read hits this bank

        assign wrSel = wrEn && (wrAddr[bankBit] == 1'(b));
        assign rdSel = rdEn && (rdAddr[bankBit] == 1'(b));

        tpSramMacro #(.width(`LO_HALF_W)) uLo (  // Bits 73..0
            .ClkB   (ClkB),
            .wrEn   (wrSel),
            .wrAddr (wrBankAddr),
            .wrData (wrWord[`LO_HALF_W-1:0]),
            .rdEn   (rdSel),
            .rdAddr (rdBankAddr),
            .rdData (bankQ[b][`LO_HALF_W-1:0])
        );

        tpSramMacro #(.width(`HI_HALF_W)) uHi (  // Bits 148..74
            .ClkB   (ClkB),
            .wrEn   (wrSel),
            .wrAddr (wrBankAddr),
            .wrData (wrWord[`WORD_W-1:`LO_HALF_W]),
            .rdEn   (rdSel),
            .rdAddr (rdBankAddr),
            .rdData (bankQ[b][`WORD_W-1:`LO_HALF_W])
        );
    end

    // ==========================================================
    // Output mux
    // ==========================================================
    // Macros have no output stage, so one cycle of delay lines up with Q
    always_ff @(posedge ClkB) begin
        if (rdEn) begin
            rdBankQ <= rdAddr[bankBit];  // Hold for the data cycle
        end
    end

    assign rdWord = bankQ[rdBankQ];  // Steer the bank that was read

    // Mux select must be known when the read data lands
    aBankSelKnown: assert property (@(posedge ClkB) rdEn |=> !$isunknown(rdBankQ));

endmodule

// ==== logic/bufferCtrl.sv ====
// Descriptor buffer control
// Scrub after reset, then FIFO pointers, occupancy, flags and RAM port control
`timescale 1ns/10ps
`include "descBuffer_config.svh"

module bufferCtrl (
    input  logic                ClkB,
    input  logic                rstN,
    input  logic                pushEn,
    input  logic                popEn,
    input  logic                flushEn,
    output logic                wrEn,
    output memGeomPkg::ramAddrT wrAddr,
    output logic                scrubbing,
    output logic                rdEn,
    output memGeomPkg::ramAddrT rdAddr,
    output logic                popValid,
    output logic                ready,
    output logic                full,
    output logic                empty,
    output logic                overflow,
    output logic                underflow,
    output descBufPkg::countT   count
);

    import memGeomPkg::*;
    import descBufPkg::*;

    ctrlStateT state;
    ramAddrT   scrubAddr;  // Zero-fill address
    ramAddrT   wrPtr;
    ramAddrT   rdPtr;
    countT     countNext;
    logic      pushAcc;    // Push taken this cycle
    logic      popAcc;     // Pop taken this cycle
    logic      pushDrop;   // Push refused, buffer full
    logic      popDrop;    // Pop refused, buffer empty

    // ==========================================================
    // Scrub FSM
    // ==========================================================
    always_ff @(posedge ClkB or negedge rstN) begin
        if (!rstN) begin
            state     <= stScrub;
            scrubAddr <= '0;
        end else if (state == stScrub) begin
            scrubAddr <= scrubAddr + 1'b1;  // One zero word per cycle
            if (scrubAddr == ramAddrT'(`BUF_DEPTH - 1)) begin
                state <= stRun;  // Last entry written this edge
            end
        end
    end

    assign scrubbing = (state == stScrub);
    assign ready     = (state == stRun);

    // Flush wins, flags sampled before the cycle
    assign pushAcc  = pushEn && ready && !full && !flushEn;
    assign popAcc   = popEn && ready && !empty && !flushEn;
    assign pushDrop = pushEn && ready && full && !flushEn;
    assign popDrop  = popEn && ready && empty && !flushEn;

    // RAM ports
    assign wrEn   = scrubbing || pushAcc;
    assign wrAddr = scrubbing ? scrubAddr : wrPtr;
    assign rdEn   = popAcc;  // Same-cycle read request
    assign rdAddr = rdPtr;

    // ==========================================================
    // Occupancy and flags
    // ==========================================================
    always_comb begin
        countNext = count;
        if (flushEn) begin
            countNext = '0;
        end else if (pushAcc && !popAcc) begin
            countNext = count + 1'b1;
        end else if (popAcc && !pushAcc) begin
            countNext = count - 1'b1;
        end
    end

    always_ff @(posedge ClkB or negedge rstN) begin
        if (!rstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            full      <= 1'b0;
            empty     <= 1'b1;
            popValid  <= 1'b0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (flushEn) begin
                wrPtr <= '0;
                rdPtr <= '0;
            end else begin
                if (pushAcc) wrPtr <= wrPtr + 1'b1;  // Wraps at 2048
                if (popAcc)  rdPtr <= rdPtr + 1'b1;
            end
            count     <= countNext;
            full      <= (countNext == countT'(`BUF_DEPTH));
            empty     <= (countNext == '0);
            popValid  <= popAcc;    // Lines up with RAM read data
            overflow  <= pushDrop;  // One-cycle pulses
            underflow <= popDrop;
        end
    end

    // ==========================================================
    // Checks
    // ==========================================================
    aCountBound: assert property (@(posedge ClkB) disable iff (!rstN)
        count <= countT'(`BUF_DEPTH));
    aNoAddrClash: assert property (@(posedge ClkB) disable iff (!rstN)
        (rdEn && wrEn) |-> (rdAddr != wrAddr));
    aFlagsExclusive: assert property (@(posedge ClkB) disable iff (!rstN)
        !(full && empty));

endmodule

// ==== logic/entryPack.sv ====
// Descriptor write datapath
// Packs payload, last flag and quarter parity into one stored word
`timescale 1ns/10ps

module entryPack (
    input  descBufPkg::payloadT pushPayload,
    input  logic                pushLast,
    input  logic                errInject,
    input  logic                scrubbing,
    output memGeomPkg::ramWordT wrWord
);

    import descBufPkg::*;

    parityT parity;  // Parity as stored

    // ==========================================================
    // Word assembly
    // ==========================================================
    // Layout: parity 148..145, last 144, payload 143..0
    always_comb begin
        parity    = calcParity(pushPayload);
        parity[0] = parity[0] ^ errInject;  // Fault injection on group 0
        if (scrubbing) begin
            wrWord = '0;  // All-zero word has valid parity
        end else begin
            wrWord = {parity, pushLast, pushPayload};
        end
    end

endmodule

// ==== logic/entryCheck.sv ====
// Descriptor read datapath
// Unpacks the stored word and checks quarter parity on each pop
`timescale 1ns/10ps
`include "descBuffer_config.svh"

module entryCheck (
    input  logic                ClkB,
    input  memGeomPkg::ramWordT rdWord,
    input  logic                popValid,
    output descBufPkg::payloadT popPayload,
    output logic                popLast,
    output logic                parityErr
);

    import descBufPkg::*;

    parityT storedPar;  // Parity read back
    parityT calcPar;    // Parity of the payload as read

    // ==========================================================
    // Unpack
    // ==========================================================
    assign popPayload = rdWord[`PAYLOAD_W-1:0];
    assign popLast    = rdWord[`PAYLOAD_W];
    assign storedPar  = rdWord[`WORD_W-1:`PAYLOAD_W+1];

    // ==========================================================
    // Parity check
    // ==========================================================
    assign calcPar   = calcParity(popPayload);
    assign parityErr = popValid && (storedPar != calcPar);  // Only on a real pop

    // Popped data comes from a written or scrubbed entry
    aPayloadKnown: assert property (@(posedge ClkB)
        popValid |-> !$isunknown(popPayload));

endmodule

// ==== logic/descBuffer.sv ====
// Descriptor buffer top level
// 2048-entry FIFO of 149-bit words on a banked two-port SRAM
`timescale 1ns/10ps

module descBuffer (
    input  logic                ClkB,
    input  logic                rstN,
    input  logic                pushEn,
    input  descBufPkg::payloadT pushPayload,
    input  logic                pushLast,
    input  logic                errInject,
    input  logic                popEn,
    input  logic                flushEn,
    output logic                popValid,
    output descBufPkg::payloadT popPayload,
    output logic                popLast,
    output logic                parityErr,
    output logic                ready,
    output logic                full,
    output logic                empty,
    output logic                overflow,
    output logic                underflow,
    output descBufPkg::countT   count
);

    import memGeomPkg::*;

    logic    wrEn;
    ramAddrT wrAddr;
    ramWordT wrWord;     // Packed word to RAM
    logic    rdEn;
    ramAddrT rdAddr;
    ramWordT rdWord;     // Word from RAM, one cycle after rdEn
    logic    scrubbing;  // Forces zero words

    // ==========================================================
    // Control
    // ==========================================================
    bufferCtrl uCtrl (
        .ClkB      (ClkB),
        .rstN      (rstN),
        .pushEn    (pushEn),
        .popEn     (popEn),
        .flushEn   (flushEn),
        .wrEn      (wrEn),
        .wrAddr    (wrAddr),
        .scrubbing (scrubbing),
        .rdEn      (rdEn),
        .rdAddr    (rdAddr),
        .popValid  (popValid),
        .ready     (ready),
        .full      (full),
        .empty     (empty),
        .overflow  (overflow),
        .underflow (underflow),
        .count     (count)
    );

    // ==========================================================
    // Datapath
    // ==========================================================
    entryPack uPack (
        .pushPayload (pushPayload),
        .pushLast    (pushLast),
        .errInject   (errInject),
        .scrubbing   (scrubbing),
        .wrWord      (wrWord)
    );

    bankedTpRam uRam (
        .ClkB   (ClkB),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrWord (wrWord),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdWord (rdWord)
    );

    entryCheck uCheck (
        .ClkB       (ClkB),
        .rdWord     (rdWord),
        .popValid   (popValid),
        .popPayload (popPayload),
        .popLast    (popLast),
        .parityErr  (parityErr)
    );

endmodule

// ==== bench/descBufferTb.sv ====
// Descriptor buffer testbench
// Stim file driven, queue reference model, outputs checked every cycle
`timescale 1ns/10ps
`include "descBuffer_config.svh"

module descBufferTb;

    import descBufPkg::*;

    logic    ClkB;
    logic    rstN;
    logic    pushEn;
    payloadT pushPayload;
    logic    pushLast;
    logic    errInject;
    logic    popEn;
    logic    flushEn;
    logic    popValid;
    payloadT popPayload;
    logic    popLast;
    logic    parityErr;
    logic    ready;
    logic    full;
    logic    empty;
    logic    overflow;
    logic    underflow;
    countT   count;

    logic [7:0] opQ [$];    // Stim lines
    int         cntQ [$];
    payloadT    payQ [$];
    logic       lastQ [$];
    logic       injQ [$];

    logic [`PAYLOAD_W+1:0] model [$];  // {inject, last, payload}
    logic    expValid;    // Pending results of the previous slot
    payloadT expPayload;
    logic    expLast;
    logic    expErr;
    logic    expOvf;
    logic    expUnf;
    int      seed = 32'h7d42_e583;
    int      totalOps = 0;
    logic    stimLoaded = 1'b0;

    descBuffer DUT (.*);

    initial begin
        ClkB = 1'b0;
        forever #10 ClkB = ~ClkB;  // 20 ns period
    end

    // ==========================================================
    // Failure and compare tasks
    // ==========================================================
    task automatic failRun(input string why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic checkPayload(input payloadT got, input payloadT exp);
        if (got !== exp) begin
            $display("MISMATCH popPayload: got %h expected %h", got, exp);
            failRun("payload compare");
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            failRun("flag compare");
        end
    endtask

    task automatic checkCount(input countT got, input countT exp);
        if (got !== exp) begin
            $display("MISMATCH count: got %h expected %h", got, exp);
            failRun("count compare");
        end
    endtask

    // ==========================================================
    // Reference model
    // ==========================================================
    // Burst payload keeps the base tag in the top 16 bits
    task automatic makePayload(input payloadT base, output payloadT pay, output logic lst);
        int r;
        pay = base;
        for (int w = 0; w < 4; w++) begin
            r = $random(seed);
            pay[w*32 +: 32] = r;  // Random low 128 bits
        end
        r = $random(seed);
        lst = r[0];
    endtask

    // Acceptance taken on the occupancy before the cycle
    task automatic applyOp(input logic [7:0] op, input payloadT pay, input logic lst,
                           input logic inj);
        logic                  pushOk;
        logic                  popOk;
        logic [`PAYLOAD_W+1:0] head;
        pushOk   = (op == "P" || op == "S") && model.size() < `BUF_DEPTH;
        popOk    = (op == "O" || op == "S") && model.size() > 0;
        expOvf   = (op == "P" || op == "S") && model.size() == `BUF_DEPTH;
        expUnf   = (op == "O" || op == "S") && model.size() == 0;
        expValid = popOk;  // popValid one cycle later
        if (op == "F") model.delete();
        if (popOk) begin
            head = model.pop_front();
            {expErr, expLast, expPayload} = head;  // Injected entry must flag parity
        end
        if (pushOk) model.push_back({inj, lst, pay});
    endtask

    // Drive on the rising edge, check the previous slot at the falling edge
    task automatic runSlot(input logic [7:0] op, input payloadT pay, input logic lst,
                           input logic inj);
        @(posedge ClkB);
        pushEn      <= (op == "P" || op == "S");
        popEn       <= (op == "O" || op == "S");
        flushEn     <= (op == "F");
        pushPayload <= pay;
        pushLast    <= lst;
        errInject   <= inj;
        @(negedge ClkB);
        checkFlag("popValid", popValid, expValid);
        if (expValid) begin
            checkPayload(popPayload, expPayload);
            checkFlag("popLast", popLast, expLast);
        end
        checkFlag("parityErr", parityErr, expValid && expErr);
        checkFlag("overflow", overflow, expOvf);
        checkFlag("underflow", underflow, expUnf);
        checkFlag("ready", ready, 1'b1);
        checkCount(count, countT'(model.size()));  // Registered flags lag one edge
        checkFlag("full", full, model.size() == `BUF_DEPTH);
        checkFlag("empty", empty, model.size() == 0);
        applyOp(op, pay, lst, inj);
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        int         fd;
        int         n;
        string      line;
        logic [7:0] opChar;
        int         cnt;
        payloadT    pay;
        int         lstI;
        int         injI;
        logic       lstB;
        rstN        = 1'b0;
        pushEn      = 1'b0;
        popEn       = 1'b0;
        flushEn     = 1'b0;
        pushPayload = '0;
        pushLast    = 1'b0;
        errInject   = 1'b0;
        expValid    = 1'b0;
        expPayload  = '0;
        expLast     = 1'b0;
        expErr      = 1'b0;
        expOvf      = 1'b0;
        expUnf      = 1'b0;
        fd = $fopen("bench/descBuffer_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bench/descBuffer_stim.txt");
            failRun("missing stimulus");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            n = $sscanf(line, "%c %d %h %d %d", opChar, cnt, pay, lstI, injI);
            if (n == 5 && opChar != "#") begin
                if (!(opChar inside {"P", "O", "S", "F", "I"}) || cnt < 1) begin
                    $display("Bad line in stimulus file: %s", line);
                    failRun("bad stimulus");
                end else begin
                    opQ.push_back(opChar);
                    cntQ.push_back(cnt);
                    payQ.push_back(pay);
                    lastQ.push_back(lstI[0]);
                    injQ.push_back(injI[0]);
                    totalOps += cnt;  // Bursts count in full
                end
            end
        end
        $fclose(fd);
        stimLoaded = 1'b1;

        // Reset, then scrub with push and pop held high to prove they are ignored
        repeat (10) @(posedge ClkB);
        rstN   <= 1'b1;
        pushEn <= 1'b1;
        popEn  <= 1'b1;
        for (int cyc = 0; cyc <= `BUF_DEPTH; cyc++) begin
            if (cyc > 0) begin
                @(posedge ClkB);
                if (cyc == `BUF_DEPTH) begin
                    pushEn <= 1'b0;  // Idle before the first run edge
                    popEn  <= 1'b0;
                end
            end
            @(negedge ClkB);
            checkFlag("ready", ready, cyc == `BUF_DEPTH);  // High after exactly 2048 edges
            checkFlag("empty", empty, 1'b1);
            checkFlag("full", full, 1'b0);
            checkCount(count, '0);
            checkFlag("popValid", popValid, 1'b0);
            checkFlag("overflow", overflow, 1'b0);
            checkFlag("underflow", underflow, 1'b0);
        end

        for (int i = 0; i < opQ.size(); i++) begin
            for (int k = 0; k < cntQ[i]; k++) begin
                pay  = payQ[i];
                lstB = lastQ[i];
                if (cntQ[i] > 1) makePayload(payQ[i], pay, lstB);
                runSlot(opQ[i], pay, lstB, injQ[i]);
            end
        end
        runSlot("I", '0, 1'b0, 1'b0);  // Collect the last results

        $display("TB PASSED");
        $finish;
    end

    // Scrub plus four cycles per operation plus margin
    initial begin
        wait (stimLoaded === 1'b1);
        repeat (`BUF_DEPTH + 4 * totalOps + 200) @(posedge ClkB);
        $display("Timeout: the run did not finish within its cycle budget");
        failRun("watchdog expired");
    end

endmodule

// ==== descBuffer.f ====
+incdir+include
logic/memGeomPkg.sv
logic/descBufPkg.sv
logic/tpSramMacro.sv
logic/bankedTpRam.sv
logic/bufferCtrl.sv
logic/entryPack.sv
logic/entryCheck.sv
logic/descBuffer.sv
bench/descBufferTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build the descriptor buffer testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module descBufferTb -f descBuffer.f -o descBufferSim &&
./obj_dir/descBufferSim || { echo "build or simulation returned an error"; exit 1; }

// ==== bench/descBuffer_stim.txt ====
# op count payload_hex last inject  (P push, O pop, S push+pop, F flush, I idle)
# count > 1 is a burst: payload column is a base tag, low 128 bits and last are random
P 1 0123456789abcdef0123456789abcdef0123 1 0
P 1 fedcba9876543210fedcba9876543210fedc 0 0
P 1 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 1 1
O 1 0 0 0
I 1 0 0 0
O 1 0 0 0
O 1 0 0 0
O 1 0 0 0
P 1 ffffffffffffffffffffffffffffffffffff 0 0
S 1 000000000000000000000000000000000001 1 0
S 1 800000000000000000000000000000000000 0 1
O 1 0 0 0
P 2048 c0de00000000000000000000000000000000 0 0
P 1 0000000000000000000000000000deadbeef 1 0
S 1 000000000000000000000000000000001234 0 0
S 16 5a5a00000000000000000000000000000000 0 0
O 2047 0 0 0
O 1 0 0 0
S 1 3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c 1 0
O 1 0 0 0
P 3 f1f100000000000000000000000000000000 0 0
F 1 0 0 0
P 1 00000000000000000000000000000000beef 1 0
O 1 0 0 0
O 1 0 0 0
P 4 e4e400000000000000000000000000000000 0 1
O 4 0 0 0
I 2 0 0 0
